//--- rtl/vga_pkg.sv
package vga_pkg;

  // 640x480 at 60 Hz, all in pixels / lines
  localparam int H_DISPLAY = 640;
  localparam int H_FRONT   = 16;
  localparam int H_SYNC    = 96;
  localparam int H_BACK    = 48;
  localparam int H_TOTAL   = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;

  localparam int V_DISPLAY = 480;
  localparam int V_FRONT   = 10;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 33;
  localparam int V_TOTAL   = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;

  // 100 MHz clock, 25 MHz pixel rate
  localparam int CLK_PER_PIXEL = 4;
  localparam int PIX_DIV_W     = $clog2(CLK_PER_PIXEL);

  localparam int H_CNT_W = 10;
  localparam int V_CNT_W = 10;

  typedef enum logic [1:0] {
    DISPLAY,
    FRONT,
    SYNC,
    BACK
  } scan_state_e;

endpackage

//--- rtl/text_pkg.sv
package text_pkg;

  localparam int GRID_COLS = 80;
  localparam int GRID_ROWS = 30;

  localparam int GLYPH_W     = 8;
  localparam int GLYPH_H     = 16;
  localparam int GLYPH_BITS  = GLYPH_W * GLYPH_H;
  localparam int GLYPH_X_W   = $clog2(GLYPH_W);
  localparam int GLYPH_Y_W   = $clog2(GLYPH_H);
  localparam int GLYPH_IDX_W = $clog2(GLYPH_BITS);

  localparam int CELL_ADDR_W = 12;

  localparam int HOST_ADDR_W = 10;
  localparam int HOST_DATA_W = 32;
  localparam int HOST_BE_W   = 4;
  localparam int BYTE_W      = HOST_DATA_W / HOST_BE_W;
  localparam int LANE_W      = $clog2(HOST_BE_W);

  // glyph spread over 32-bit banks
  localparam int FONT_CODE_W = 7;
  localparam int FONT_BANKS  = GLYPH_BITS / HOST_DATA_W;
  localparam int FONT_BANK_W = $clog2(FONT_BANKS);

  localparam int COLOR_W = 4;
  localparam int RGB_W   = 3 * COLOR_W;

  typedef enum logic [COLOR_W-1:0] {
    BLACK, BLUE, GREEN, CYAN,
    RED, MAGENTA, BROWN, LIGHT_GRAY,
    DARK_GRAY, LIGHT_BLUE, LIGHT_GREEN, LIGHT_CYAN,
    LIGHT_RED, LIGHT_MAGENTA, YELLOW, WHITE
  } color_e;

  // 12-bit {r, g, b}
  function automatic logic [RGB_W-1:0] palette(color_e c);
    logic [RGB_W-1:0] rgb;
    unique case (c)
      BLACK:         rgb = 12'h000;
      BLUE:          rgb = 12'h00a;
      GREEN:         rgb = 12'h0a0;
      CYAN:          rgb = 12'h0aa;
      RED:           rgb = 12'ha00;
      MAGENTA:       rgb = 12'ha0a;
      BROWN:         rgb = 12'ha50;
      LIGHT_GRAY:    rgb = 12'haaa;
      DARK_GRAY:     rgb = 12'h555;
      LIGHT_BLUE:    rgb = 12'h55f;
      LIGHT_GREEN:   rgb = 12'h5f5;
      LIGHT_CYAN:    rgb = 12'h5ff;
      LIGHT_RED:     rgb = 12'hf55;
      LIGHT_MAGENTA: rgb = 12'hf5f;
      YELLOW:        rgb = 12'hff5;
      WHITE:         rgb = 12'hfff;
    endcase
    return rgb;
  endfunction

endpackage

//--- rtl/host_bus_if.sv
interface host_bus_if;

  logic [text_pkg::HOST_ADDR_W-1:0] addr;
  logic                             we;
  logic [text_pkg::HOST_BE_W-1:0]   be;
  logic [text_pkg::HOST_DATA_W-1:0] wdata;
  logic [text_pkg::HOST_DATA_W-1:0] rdata; // one cycle after addr

  modport host (
    output addr, we, be, wdata,
    input  rdata
  );

  modport mem (
    input  addr, we, be, wdata,
    output rdata
  );

endinterface

//--- rtl/scan_if.sv
interface scan_if;

  logic [vga_pkg::H_CNT_W-1:0] hcount;
  logic [vga_pkg::V_CNT_W-1:0] vcount;
  logic                        disp_en;
  logic                        hs;       // active low
  logic                        vs;       // active low

  modport src (
    output hcount, vcount, disp_en, hs, vs
  );

  modport dst (
    input  hcount, vcount, disp_en, hs, vs
  );

endinterface

//--- rtl/vga_timing.sv
module vga_timing (
  input  logic clk_i,
  input  logic arstn_i,
  scan_if.src  scan_o
);

  logic [vga_pkg::PIX_DIV_W-1:0] div_q;
  logic                          strobe;

  logic [vga_pkg::H_CNT_W-1:0] hcount_q;
  logic [vga_pkg::H_CNT_W-1:0] hcount_next;
  logic [vga_pkg::V_CNT_W-1:0] vcount_q;
  logic [vga_pkg::V_CNT_W-1:0] vcount_next;
  logic                        line_end;

  vga_pkg::scan_state_e hstate_q, hstate_next;
  vga_pkg::scan_state_e vstate_q, vstate_next;

  logic disp_en_q;
  logic hs_q;
  logic vs_q;

  // pixel strobe, first one CLK_PER_PIXEL cycles out of reset
  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      div_q <= vga_pkg::PIX_DIV_W'(vga_pkg::CLK_PER_PIXEL - 1);
    end else if (strobe) begin
      div_q <= vga_pkg::PIX_DIV_W'(vga_pkg::CLK_PER_PIXEL - 1);
    end else begin
      div_q <= div_q - 1'b1;
    end
  end

  assign strobe = (div_q == '0);

  assign line_end    = (hcount_q == vga_pkg::H_CNT_W'(vga_pkg::H_TOTAL - 1));
  assign hcount_next = line_end ? '0 : hcount_q + 1'b1;
  assign vcount_next = (vcount_q == vga_pkg::V_CNT_W'(vga_pkg::V_TOTAL - 1)) ? '0
                                                                              : vcount_q + 1'b1;

  always_comb begin
    hstate_next = hstate_q;
    unique case (hstate_q)
      vga_pkg::DISPLAY: if (hcount_q == vga_pkg::H_DISPLAY - 1) hstate_next = vga_pkg::FRONT;
      vga_pkg::FRONT: begin
        if (hcount_q == vga_pkg::H_DISPLAY + vga_pkg::H_FRONT - 1) hstate_next = vga_pkg::SYNC;
      end
      vga_pkg::SYNC: begin
        if (hcount_q == vga_pkg::H_TOTAL - vga_pkg::H_BACK - 1) hstate_next = vga_pkg::BACK;
      end
      vga_pkg::BACK:    if (line_end) hstate_next = vga_pkg::DISPLAY;
    endcase
  end

  // vertical phases only move at the end of a line
  always_comb begin
    vstate_next = vstate_q;
    if (line_end) begin
      unique case (vstate_q)
        vga_pkg::DISPLAY: if (vcount_q == vga_pkg::V_DISPLAY - 1) vstate_next = vga_pkg::FRONT;
        vga_pkg::FRONT: begin
          if (vcount_q == vga_pkg::V_DISPLAY + vga_pkg::V_FRONT - 1) vstate_next = vga_pkg::SYNC;
        end
        vga_pkg::SYNC: begin
          if (vcount_q == vga_pkg::V_TOTAL - vga_pkg::V_BACK - 1) vstate_next = vga_pkg::BACK;
        end
        vga_pkg::BACK:    if (vcount_q == vga_pkg::V_TOTAL - 1) vstate_next = vga_pkg::DISPLAY;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      hcount_q  <= '0;
      vcount_q  <= '0;
      hstate_q  <= vga_pkg::DISPLAY;
      vstate_q  <= vga_pkg::DISPLAY;
      disp_en_q <= 1'b0;
      hs_q      <= 1'b1;
      vs_q      <= 1'b1;
    end else if (strobe) begin
      hcount_q  <= hcount_next;
      if (line_end) vcount_q <= vcount_next;
      hstate_q  <= hstate_next;
      vstate_q  <= vstate_next;
      disp_en_q <= (hstate_next == vga_pkg::DISPLAY) && (vstate_next == vga_pkg::DISPLAY);
      hs_q      <= (hstate_next != vga_pkg::SYNC);
      vs_q      <= (vstate_next != vga_pkg::SYNC);
    end
  end

  assign scan_o.hcount  = hcount_q;
  assign scan_o.vcount  = vcount_q;
  assign scan_o.disp_en = disp_en_q;
  assign scan_o.hs      = hs_q;
  assign scan_o.vs      = vs_q;

  a_hcount_range: assert property (@(posedge clk_i) disable iff (!arstn_i)
    hcount_q < vga_pkg::H_CNT_W'(vga_pkg::H_TOTAL));

  a_disp_area: assert property (@(posedge clk_i) disable iff (!arstn_i)
    disp_en_q |-> (hcount_q < vga_pkg::H_DISPLAY) && (vcount_q < vga_pkg::V_DISPLAY));

endmodule

//--- rtl/byte_ram.sv
module byte_ram (
  input  logic                             clk_i,
  host_bus_if.mem                          host_i,
  input  logic [text_pkg::HOST_ADDR_W-1:0] rd_addr_i,
  output logic [text_pkg::HOST_DATA_W-1:0] rd_data_o
);

  logic [text_pkg::HOST_DATA_W-1:0] mem [2**text_pkg::HOST_ADDR_W];

  // lane-wise host writes
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < text_pkg::HOST_BE_W; i++) begin
      if (host_i.we && host_i.be[i]) begin
        mem[host_i.addr][i*text_pkg::BYTE_W +: text_pkg::BYTE_W] <=
          host_i.wdata[i*text_pkg::BYTE_W +: text_pkg::BYTE_W];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    host_i.rdata <= mem[host_i.addr]; // old word on a write cycle
  end

  // pixel side
  always_ff @(posedge clk_i) begin
    rd_data_o <= mem[rd_addr_i];
  end

  a_wr_addr_known: assert property (@(posedge clk_i)
    host_i.we |-> !$isunknown(host_i.addr));

endmodule

//--- rtl/font_ram.sv
module font_ram (
  input  logic                            clk_i,
  host_bus_if.mem                         host_i,
  input  logic [text_pkg::FONT_CODE_W-1:0] code_i,
  output logic [text_pkg::GLYPH_BITS-1:0]  glyph_o
);

  logic [text_pkg::FONT_BANK_W-1:0] bank_a;
  logic [text_pkg::FONT_CODE_W-1:0] code_a;
  logic [text_pkg::FONT_BANK_W-1:0] bank_sel_q;

  logic [text_pkg::HOST_DATA_W-1:0] host_word  [text_pkg::FONT_BANKS];
  logic [text_pkg::HOST_DATA_W-1:0] glyph_word [text_pkg::FONT_BANKS];

  // word address = 4 * code + bank, top address bit unused
  assign bank_a = host_i.addr[text_pkg::FONT_BANK_W-1:0];
  assign code_a = host_i.addr[text_pkg::FONT_BANK_W +: text_pkg::FONT_CODE_W];

  for (genvar k = 0; k < text_pkg::FONT_BANKS; k++) begin : g_bank
    logic [text_pkg::HOST_DATA_W-1:0] mem [2**text_pkg::FONT_CODE_W];

    always_ff @(posedge clk_i) begin
      for (int i = 0; i < text_pkg::HOST_BE_W; i++) begin
        if (host_i.we && host_i.be[i] && bank_a == text_pkg::FONT_BANK_W'(k)) begin
          mem[code_a][i*text_pkg::BYTE_W +: text_pkg::BYTE_W] <=
            host_i.wdata[i*text_pkg::BYTE_W +: text_pkg::BYTE_W];
        end
      end
      host_word[k]  <= mem[code_a];
      glyph_word[k] <= mem[code_i]; // all banks read at once
    end
  end

  always_ff @(posedge clk_i) begin
    bank_sel_q <= bank_a;
  end

  assign host_i.rdata = host_word[bank_sel_q];

  always_comb begin
    for (int k = 0; k < text_pkg::FONT_BANKS; k++) begin
      glyph_o[k*text_pkg::HOST_DATA_W +: text_pkg::HOST_DATA_W] = glyph_word[k];
    end
  end

endmodule

//--- rtl/text_pipeline.sv
module text_pipeline (
  input  logic                         clk_i,
  input  logic                         arstn_i,
  scan_if.dst                          scan_i,
  host_bus_if.mem                      char_bus_i,
  host_bus_if.mem                      color_bus_i,
  host_bus_if.mem                      font_bus_i,
  output logic [text_pkg::COLOR_W-1:0] vga_r_o,
  output logic [text_pkg::COLOR_W-1:0] vga_g_o,
  output logic [text_pkg::COLOR_W-1:0] vga_b_o,
  output logic                         vga_hs_o,
  output logic                         vga_vs_o
);

  logic [text_pkg::CELL_ADDR_W-1:0] cell_row;
  logic [text_pkg::CELL_ADDR_W-1:0] cell_col;
  logic [text_pkg::CELL_ADDR_W-1:0] cell_idx;
  logic [text_pkg::GLYPH_IDX_W-1:0] bit_idx;

  logic [text_pkg::HOST_DATA_W-1:0] char_word;
  logic [text_pkg::HOST_DATA_W-1:0] color_word;
  logic [text_pkg::BYTE_W-1:0]      char_byte;
  logic [text_pkg::BYTE_W-1:0]      color_byte;
  logic [text_pkg::GLYPH_BITS-1:0]  glyph;

  logic [text_pkg::LANE_W-1:0]      lane_q1;
  logic [text_pkg::GLYPH_IDX_W-1:0] bit_idx_q1;
  logic [text_pkg::GLYPH_IDX_W-1:0] bit_idx_q2;
  logic [text_pkg::BYTE_W-1:0]      color_q2;

  logic [1:0] disp_d;
  logic [1:0] hs_d;
  logic [1:0] vs_d;

  logic                       pix_on;
  logic [text_pkg::RGB_W-1:0] fg_rgb;
  logic [text_pkg::RGB_W-1:0] bg_rgb;
  logic [text_pkg::RGB_W-1:0] rgb_next;

  // cell = 80 * row + col
  assign cell_row = text_pkg::CELL_ADDR_W'(scan_i.vcount >> text_pkg::GLYPH_Y_W);
  assign cell_col = text_pkg::CELL_ADDR_W'(scan_i.hcount >> text_pkg::GLYPH_X_W);
  assign cell_idx = cell_row * text_pkg::CELL_ADDR_W'(text_pkg::GRID_COLS) + cell_col;
  assign bit_idx  = {scan_i.vcount[text_pkg::GLYPH_Y_W-1:0], scan_i.hcount[text_pkg::GLYPH_X_W-1:0]};

  byte_ram char_map_i (
    .clk_i     (clk_i),
    .host_i    (char_bus_i),
    .rd_addr_i (cell_idx[text_pkg::CELL_ADDR_W-1:text_pkg::LANE_W]),
    .rd_data_o (char_word)
  );

  byte_ram color_map_i (
    .clk_i     (clk_i),
    .host_i    (color_bus_i),
    .rd_addr_i (cell_idx[text_pkg::CELL_ADDR_W-1:text_pkg::LANE_W]),
    .rd_data_o (color_word)
  );

  assign char_byte  = char_word[lane_q1*text_pkg::BYTE_W +: text_pkg::BYTE_W];
  assign color_byte = color_word[lane_q1*text_pkg::BYTE_W +: text_pkg::BYTE_W];

  font_ram font_i (
    .clk_i   (clk_i),
    .host_i  (font_bus_i),
    .code_i  (char_byte[text_pkg::FONT_CODE_W-1:0]), // bit 7 ignored
    .glyph_o (glyph)
  );

  always_ff @(posedge clk_i) begin
    lane_q1    <= cell_idx[text_pkg::LANE_W-1:0];
    bit_idx_q1 <= bit_idx;
    bit_idx_q2 <= bit_idx_q1;
    color_q2   <= color_byte; // lines up with glyph
  end

  // two stages to match the map and font reads
  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      disp_d <= '0;
      hs_d   <= '1;
      vs_d   <= '1;
    end else begin
      disp_d <= {disp_d[0], scan_i.disp_en};
      hs_d   <= {hs_d[0], scan_i.hs};
      vs_d   <= {vs_d[0], scan_i.vs};
    end
  end

  assign pix_on = glyph[bit_idx_q2];
  assign fg_rgb = text_pkg::palette(text_pkg::color_e'(color_q2[text_pkg::BYTE_W-1 -: text_pkg::COLOR_W]));
  assign bg_rgb = text_pkg::palette(text_pkg::color_e'(color_q2[text_pkg::COLOR_W-1:0]));

  assign rgb_next = disp_d[1] ? (pix_on ? fg_rgb : bg_rgb) : '0;

  always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
      vga_r_o  <= '0;
      vga_g_o  <= '0;
      vga_b_o  <= '0;
      vga_hs_o <= 1'b1;
      vga_vs_o <= 1'b1;
    end else begin
      vga_r_o  <= rgb_next[2*text_pkg::COLOR_W +: text_pkg::COLOR_W];
      vga_g_o  <= rgb_next[text_pkg::COLOR_W +: text_pkg::COLOR_W];
      vga_b_o  <= rgb_next[0 +: text_pkg::COLOR_W];
      vga_hs_o <= hs_d[1];
      vga_vs_o <= vs_d[1];
    end
  end

  // display area from the timing block must map inside the grid
  a_cell_in_grid: assert property (@(posedge clk_i) disable iff (!arstn_i)
    scan_i.disp_en |-> cell_idx < text_pkg::CELL_ADDR_W'(text_pkg::GRID_COLS * text_pkg::GRID_ROWS));

endmodule

//--- rtl/vga_text_top.sv
module vga_text_top (
  input  logic                             clk_i,
  input  logic                             arstn_i,

  input  logic [text_pkg::HOST_ADDR_W-1:0] char_map_addr_i,
  input  logic                             char_map_we_i,
  input  logic [text_pkg::HOST_BE_W-1:0]   char_map_be_i,
  input  logic [text_pkg::HOST_DATA_W-1:0] char_map_wdata_i,
  output logic [text_pkg::HOST_DATA_W-1:0] char_map_rdata_o,

  input  logic [text_pkg::HOST_ADDR_W-1:0] col_map_addr_i,
  input  logic                             col_map_we_i,
  input  logic [text_pkg::HOST_BE_W-1:0]   col_map_be_i,
  input  logic [text_pkg::HOST_DATA_W-1:0] col_map_wdata_i,
  output logic [text_pkg::HOST_DATA_W-1:0] col_map_rdata_o,

  input  logic [text_pkg::HOST_ADDR_W-1:0] font_addr_i,
  input  logic                             font_we_i,
  input  logic [text_pkg::HOST_BE_W-1:0]   font_be_i,
  input  logic [text_pkg::HOST_DATA_W-1:0] font_wdata_i,
  output logic [text_pkg::HOST_DATA_W-1:0] font_rdata_o,

  output logic [text_pkg::COLOR_W-1:0]     vga_r_o,
  output logic [text_pkg::COLOR_W-1:0]     vga_g_o,
  output logic [text_pkg::COLOR_W-1:0]     vga_b_o,
  output logic                             vga_hs_o,
  output logic                             vga_vs_o
);

  host_bus_if char_bus ();
  host_bus_if color_bus ();
  host_bus_if font_bus ();
  scan_if     scan ();

  assign char_bus.addr    = char_map_addr_i;
  assign char_bus.we      = char_map_we_i;
  assign char_bus.be      = char_map_be_i;
  assign char_bus.wdata   = char_map_wdata_i;
  assign char_map_rdata_o = char_bus.rdata;

  assign color_bus.addr  = col_map_addr_i;
  assign color_bus.we    = col_map_we_i;
  assign color_bus.be    = col_map_be_i;
  assign color_bus.wdata = col_map_wdata_i;
  assign col_map_rdata_o = color_bus.rdata;

  assign font_bus.addr  = font_addr_i;
  assign font_bus.we    = font_we_i;
  assign font_bus.be    = font_be_i;
  assign font_bus.wdata = font_wdata_i;
  assign font_rdata_o   = font_bus.rdata;

  vga_timing timing_i (
    .clk_i   (clk_i),
    .arstn_i (arstn_i),
    .scan_o  (scan)
  );

  text_pipeline pipe_i (
    .clk_i       (clk_i),
    .arstn_i     (arstn_i),
    .scan_i      (scan),
    .char_bus_i  (char_bus),
    .color_bus_i (color_bus),
    .font_bus_i  (font_bus),
    .vga_r_o     (vga_r_o),
    .vga_g_o     (vga_g_o),
    .vga_b_o     (vga_b_o),
    .vga_hs_o    (vga_hs_o),
    .vga_vs_o    (vga_vs_o)
  );

endmodule

//--- bench/tb_vga_text.sv
module tb_vga_text;

  localparam int HS_LIMIT = 4000;      // a bit over one line
  localparam int VS_LIMIT = 2_000_000; // over one frame

  logic                                  clk_i = 1'b0;
  logic                                  arstn_i = 1'b0;
  logic [2:0][text_pkg::HOST_ADDR_W-1:0] addr = '0; // 0 char map, 1 color map, 2 font
  logic [2:0]                            we = '0;
  logic [2:0][text_pkg::HOST_BE_W-1:0]   be = '0;
  logic [2:0][text_pkg::HOST_DATA_W-1:0] wdata = '0;
  wire  [2:0][text_pkg::HOST_DATA_W-1:0] rdata;
  logic [text_pkg::COLOR_W-1:0]          vga_r;
  logic [text_pkg::COLOR_W-1:0]          vga_g;
  logic [text_pkg::COLOR_W-1:0]          vga_b;
  logic                                  vga_hs;
  logic                                  vga_vs;

  integer seed = 32'hfba8;
  int     errs;
  int     total_errs;
  int     n_pass;
  int     n_fail;
  bit     timed_out;

  // read-back memory, word address and byte enables of the second write
  int         rb_sel  [8] = '{0, 0, 1, 1, 1, 2, 2, 2};
  logic [9:0] rb_addr [8] = '{10'd3, 10'd1023, 10'd77, 10'd300,
                              10'd512, 10'd5, 10'd130, 10'd1022};
  logic [3:0] rb_be   [8] = '{4'b0101, 4'b1000, 4'b0110, 4'b0000,
                              4'b0001, 4'b1010, 4'b1111, 4'b0011};

  // screen cells as map word, lane enable, code, {fg, bg}, glyph words 0-1 and 2-3
  logic [9:0]  cell_word [5] = '{10'd0, 10'd101, 10'd599, 10'd250, 10'd400};
  logic [3:0]  cell_be   [5] = '{4'b0010, 4'b1000, 4'b1000, 4'b0001, 4'b0100};
  logic [7:0]  cell_code [5] = '{8'h41, 8'h12, 8'hff, 8'h30, 8'h05}; // ff has bit 7 set
  logic [7:0]  cell_attr [5] = '{8'he1, 8'hf4, 8'ha5, 8'h36, 8'hc8};
  logic [31:0] glyph_lo  [5] = '{32'h0f0f0f0f, 32'h00ff00ff, 32'h81818181,
                                 32'hffffffff, 32'haaaaaaaa};
  logic [31:0] glyph_hi  [5] = '{32'h0f0f0f0f, 32'h00ff00ff, 32'h81818181,
                                 32'h00000000, 32'haaaaaaaa};

  // probes in scan order with cell row/col, pixel in cell, 0 bg / 1 fg / 2 blank, color
  int pr_row [16] = '{0, 0, 5, 5, 5, 12, 12, 20, 20, 20, 29, 29, 29, 30, 30, 30};
  int pr_col [16] = '{1, 1, 7, 7, 81, 40, 40, 2, 2, 87, 79, 79, 79, 79, 10, 40};
  int pr_px  [16] = '{2, 6, 3, 3, 2, 5, 5, 1, 4, 4, 0, 3, 7, 7, 0, 0};
  int pr_py  [16] = '{3, 9, 4, 7, 10, 2, 12, 0, 6, 8, 1, 5, 15, 4, 10, 11};
  int pr_sel [16] = '{1, 0, 1, 0, 2, 1, 0, 1, 0, 2, 1, 0, 1, 2, 2, 2};
  text_pkg::color_e pr_color [16] = '{
    text_pkg::YELLOW, text_pkg::BLUE, text_pkg::WHITE, text_pkg::RED,
    text_pkg::BLACK, text_pkg::CYAN, text_pkg::BROWN, text_pkg::LIGHT_RED,
    text_pkg::DARK_GRAY, text_pkg::BLACK, text_pkg::LIGHT_GREEN, text_pkg::MAGENTA,
    text_pkg::LIGHT_GREEN, text_pkg::BLACK, text_pkg::BLACK, text_pkg::BLACK
  };

  always #50 clk_i = ~clk_i;

  vga_text_top dut_i (
    .clk_i            (clk_i),
    .arstn_i          (arstn_i),
    .char_map_addr_i  (addr[0]),
    .char_map_we_i    (we[0]),
    .char_map_be_i    (be[0]),
    .char_map_wdata_i (wdata[0]),
    .char_map_rdata_o (rdata[0]),
    .col_map_addr_i   (addr[1]),
    .col_map_we_i     (we[1]),
    .col_map_be_i     (be[1]),
    .col_map_wdata_i  (wdata[1]),
    .col_map_rdata_o  (rdata[1]),
    .font_addr_i      (addr[2]),
    .font_we_i        (we[2]),
    .font_be_i        (be[2]),
    .font_wdata_i     (wdata[2]),
    .font_rdata_o     (rdata[2]),
    .vga_r_o          (vga_r),
    .vga_g_o          (vga_g),
    .vga_b_o          (vga_b),
    .vga_hs_o         (vga_hs),
    .vga_vs_o         (vga_vs)
  );

  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic wait_sync(input bit use_vs, input logic level, input int limit,
                           output int cycles);
    cycles = 0;
    while (!timed_out && (use_vs ? vga_vs : vga_hs) !== level) begin
      if (cycles >= limit) begin
        $display("timeout: %s did not go to %0b within %0d cycles",
                 use_vs ? "vga_vs_o" : "vga_hs_o", level, limit);
        timed_out = 1'b1;
        errs++;
      end else begin
        next_cycle();
        cycles++;
      end
    end
  endtask

  task automatic write_word(input int sel, input logic [9:0] a, input logic [3:0] lanes,
                            input logic [31:0] d);
    addr[sel]  = a;
    be[sel]    = lanes;
    wdata[sel] = d;
    we[sel]    = 1'b1;
    next_cycle();
    we[sel]    = 1'b0;
  endtask

  task automatic read_word(input int sel, input logic [9:0] a, output logic [31:0] d);
    addr[sel] = a;
    next_cycle(); // registered read
    d = rdata[sel];
  endtask

  // low time and period of one sync pulse, in clock cycles
  task automatic measure_sync(input bit use_vs, input int limit, input int exp_low,
                              input int exp_period);
    int    c;
    int    low;
    string name;
    name = use_vs ? "vga_vs_o" : "vga_hs_o";
    wait_sync(use_vs, 1'b1, limit, c);
    wait_sync(use_vs, 1'b0, limit, c);
    wait_sync(use_vs, 1'b1, limit, low);
    wait_sync(use_vs, 1'b0, limit, c);
    if (!timed_out && low != exp_low) begin
      $display("Fail at %0t: %s low cycles got %0d expected %0d", $time, name, low, exp_low);
      errs++;
    end
    if (!timed_out && low + c != exp_period) begin
      $display("Fail at %0t: %s period got %0d expected %0d", $time, name, low + c,
               exp_period);
      errs++;
    end
  endtask

  task automatic report_test(input string name, input int n_err);
    if (n_err == 0) begin
      $display("test %s: pass", name);
      n_pass++;
    end else begin
      $display("test %s: fail with %0d error(s)", name, n_err);
      n_fail++;
    end
    total_errs += n_err;
  endtask

  initial begin
    logic [31:0]          w0;
    logic [31:0]          w1;
    logic [31:0]          got;
    logic [31:0]          mask;
    logic [31:0]          exp_w;
    logic [text_pkg::RGB_W-1:0] exp_rgb;
    int                   cyc;
    int                   rises;
    int                   x;
    int                   y;
    int                   blank_errs;

    // five cycles in reset, then the first one after it
    errs = 0;
    for (int i = 0; i < 6; i++) begin
      if (i == 5) arstn_i = 1'b1;
      next_cycle();
      if ({vga_hs, vga_vs, vga_r, vga_g, vga_b} !== 14'h3000) begin
        $display("Fail at %0t: {vga_hs_o,vga_vs_o,rgb} got %h expected %h", $time,
                 {vga_hs, vga_vs, vga_r, vga_g, vga_b}, 14'h3000);
        errs++;
      end
    end
    report_test("reset", errs);

    errs = 0;
    for (int i = 0; i < 8; i++) begin
      w0 = $random(seed);
      w1 = $random(seed);
      write_word(rb_sel[i], rb_addr[i], 4'hf, w0);
      write_word(rb_sel[i], rb_addr[i], rb_be[i], w1);
      read_word(rb_sel[i], rb_addr[i], got);
      for (int b = 0; b < 4; b++) begin
        mask[8*b +: 8] = {8{rb_be[i][b]}};
      end
      exp_w = (w0 & ~mask) | (w1 & mask); // disabled lanes keep the first word
      if (got !== exp_w) begin
        $display("Fail at %0t: %s got %h expected %h", $time,
                 rb_sel[i] == 0 ? "char_map_rdata_o" :
                 rb_sel[i] == 1 ? "col_map_rdata_o" : "font_rdata_o", got, exp_w);
        errs++;
      end
    end
    report_test("host read-back", errs);

    errs = 0;
    measure_sync(1'b0, HS_LIMIT, vga_pkg::H_SYNC * vga_pkg::CLK_PER_PIXEL,
                 vga_pkg::H_TOTAL * vga_pkg::CLK_PER_PIXEL);
    measure_sync(1'b1, VS_LIMIT, vga_pkg::V_SYNC * vga_pkg::H_TOTAL * vga_pkg::CLK_PER_PIXEL,
                 vga_pkg::V_TOTAL * vga_pkg::H_TOTAL * vga_pkg::CLK_PER_PIXEL);
    report_test("sync timing", errs);

    if (!timed_out) begin
      errs = 0;
      blank_errs = 0;
      // every nibble non-black in the whole color map
      for (int a = 0; a < 2**text_pkg::HOST_ADDR_W; a++) begin
        write_word(1, a[9:0], 4'hf, $random(seed) | 32'h88888888);
      end
      for (int i = 0; i < 5; i++) begin
        write_word(0, cell_word[i], cell_be[i], {4{cell_code[i]}});
        write_word(1, cell_word[i], cell_be[i], {4{cell_attr[i]}});
        for (int k = 0; k < 4; k++) begin
          write_word(2, {1'b0, cell_code[i][6:0], k[1:0]}, 4'hf,
                     (k < 2) ? glyph_lo[i] : glyph_hi[i]);
        end
      end
      rises = 0;
      wait_sync(1'b1, 1'b0, VS_LIMIT, cyc);
      wait_sync(1'b1, 1'b1, VS_LIMIT, cyc);
      for (int i = 0; i < 16 && !timed_out; i++) begin
        y = pr_row[i] * text_pkg::GLYPH_H + pr_py[i];
        x = pr_col[i] * text_pkg::GLYPH_W + pr_px[i];
        while (rises < vga_pkg::V_BACK + y && !timed_out) begin
          wait_sync(1'b0, 1'b0, HS_LIMIT, cyc);
          wait_sync(1'b0, 1'b1, HS_LIMIT, cyc);
          rises++;
        end
        repeat ((vga_pkg::H_BACK + x) * vga_pkg::CLK_PER_PIXEL + 2) next_cycle();
        exp_rgb = text_pkg::palette(pr_color[i]);
        if (!timed_out && {vga_r, vga_g, vga_b} !== exp_rgb) begin
          $display("Fail at %0t: {vga_r_o,vga_g_o,vga_b_o} at x %0d y %0d (%s) got %h expected %h",
                   $time, x, y, pr_sel[i] == 2 ? "blank" : pr_sel[i] == 1 ? "fg" : "bg",
                   {vga_r, vga_g, vga_b}, exp_rgb);
          if (pr_sel[i] == 2) blank_errs++;
          else errs++;
        end
      end
      report_test("pixel rendering", errs);
      report_test("blanking", blank_errs);
    end

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, total_errs);
    if (n_fail == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/vga_pkg.sv
rtl/text_pkg.sv
rtl/host_bus_if.sv
rtl/scan_if.sv
rtl/vga_timing.sv
rtl/byte_ram.sv
rtl/font_ram.sv
rtl/text_pipeline.sv
rtl/vga_text_top.sv
bench/tb_vga_text.sv
